// ==== Makefile ====
TOP := cpuTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f -Mdir obj_dir -o simv
	@out=$$(./obj_dir/simv +verilator+error+limit+100); echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// ==== dv/cpuBus_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuBus_chk (
  input wire logic         clk,
  input wire logic         rst,
  input wire logic         memReq,
  input wire logic         memWe,
  input wire cpuPkg::wordT memAddr,
  input wire cpuPkg::wordT memWrData,
  input wire logic         memAck,
  input wire logic         hlt
);

  int unsigned errCount = 0;  // Polled by the testbench

  // Bus quiet coming out of reset
  assert property (@(posedge clk) rst |=> !memReq)
    else begin
      errCount++;
      $error("memReq high right after reset");
    end

  // Request and payload held until ack
  assert property (@(posedge clk) disable iff (rst)
    memReq && !memAck |=> memReq && $stable(memAddr) && $stable(memWrData) && $stable(memWe))
    else begin
      errCount++;
      $error("Request dropped or changed before memAck");
    end

  // New request only after ack is gone
  assert property (@(posedge clk) disable iff (rst) $rose(memReq) |-> !$past(memAck))
    else begin
      errCount++;
      $error("memReq rose while memAck was still high");
    end

  assert property (@(posedge clk) disable iff (rst) hlt |-> !memReq)
    else begin
      errCount++;
      $error("memReq high after halt");
    end

endmodule

bind cpu cpuBus_chk busChk (
  .clk(clk), .rst(rst), .memReq(memReq), .memWe(memWe), .memAddr(memAddr),
  .memWrData(memWrData), .memAck(memAck), .hlt(hlt)
);

`default_nettype wire

// ==== dv/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTb;
  import cpuPkg::*;

  localparam int preloadBase = 'h40;  // Count, then address/data pairs
  localparam int expectBase  = 'h80;  // Count, then address/data pairs
  localparam int idleLimit   = 200;   // Cycles with no bus request
  localparam int ackLimit    = 50;
  localparam int haltLimit   = 2000;

  logic clk = 1'b0;
  logic rst;
  wordT pc;
  wordT instr = '0;
  logic memReq;
  logic memWe;
  wordT memAddr;
  wordT memWrData;
  logic memAck;
  wordT memRdData;
  logic hlt;

  wordT        image [256];    // Whole input file
  wordT        dataMem [256];
  logic [31:0] lfsr = 32'hea0b;
  int          storeIdx = 0;   // Next expected store
  int          expCount;

  cpu dut (.*);

  always #2 clk = ~clk;  // 4 ns period

  // Instruction ROM, lower part of the image
  always @(negedge clk) instr <= image[pc[5:0]];

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] lfsrStep(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // Galois, right shift
  endfunction

  // 0 to 3 cycles, one step per bit
  task automatic pickDelay(output int d);
    d = 0;
    repeat (2) begin
      lfsr = lfsrStep(lfsr);
      d = (d << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic failNow(string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic checkWord(string what, wordT got, wordT exp);
    if (got !== exp)
      failNow($sformatf("Mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic checkBit(string what, logic got, logic exp);
    if (got !== exp)
      failNow($sformatf("Mismatch at %0d ns: %s is %b, expected %b", $time, what, got, exp));
  endtask

  //////////////////////////////////////////////////
  // Data memory, four-phase slave
  //////////////////////////////////////////////////
  task automatic serveBus();
    int   waitCnt;
    int   d;
    wordT expAddr;
    wordT expData;
    waitCnt = 0;
    while (!memReq && !hlt) begin
      @(negedge clk);
      waitCnt++;
      if (waitCnt > idleLimit)
        failNow("No data bus request arrived for too long");
    end
    if (memReq) begin  // Nothing to do once halted
      pickDelay(d);
      repeat (d) @(negedge clk);
      if (memWe) begin
        if (storeIdx >= expCount)
          failNow("The core stored more words than the expected list holds");
        expAddr = image[expectBase + 1 + 2*storeIdx];
        expData = image[expectBase + 2 + 2*storeIdx];
        checkWord("store address", memAddr, expAddr);
        checkWord("store data", memWrData, expData);
        dataMem[memAddr[7:0]] = memWrData;
        storeIdx++;
      end else begin
        memRdData = dataMem[memAddr[7:0]];  // Valid while ack high
      end
      memAck = 1'b1;
      waitCnt = 0;
      while (memReq) begin
        @(negedge clk);
        waitCnt++;
        if (waitCnt > ackLimit)
          failNow("memReq stayed high long after memAck rose");
      end
      pickDelay(d);
      repeat (d) @(negedge clk);
      memAck = 1'b0;  // Access ends here
    end
  endtask

  // Bound checker counts its own assertion failures
  always @(negedge clk) begin
    if (dut.busChk.errCount != 0)
      failNow("A data bus assertion failed");
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    logic [7:0] a8;
    int         cnt;
    wordT       pcHalt;
    rst       = 1'b1;
    memAck    = 1'b0;
    memRdData = '0;
    for (int i = 0; i < 256; i++) begin
      image[i]   = '0;
      a8         = 8'(i);
      dataMem[i] = {~a8, a8};  // Distinct word per address
    end
    $readmemh("dv/progInput.txt", image);
    for (int i = 0; i < int'(image[preloadBase]); i++)
      dataMem[image[preloadBase + 1 + 2*i][7:0]] = image[preloadBase + 2 + 2*i];
    expCount = int'(image[expectBase]);

    repeat (2) @(negedge clk);  // Two rising edges in reset
    checkWord("pc in reset", pc, '0);
    checkBit("memReq in reset", memReq, 1'b0);
    checkBit("hlt in reset", hlt, 1'b0);
    rst = 1'b0;

    fork
      while (!hlt)
        serveBus();
    join_none

    cnt = 0;
    while (!hlt) begin
      @(negedge clk);
      cnt++;
      if (cnt > haltLimit)
        failNow("hlt never rose after the program started");
    end

    // Core must stay frozen
    pcHalt = pc;
    repeat (20) begin
      @(negedge clk);
      checkWord("pc after halt", pc, pcHalt);
      checkBit("hlt after halt", hlt, 1'b1);
      checkBit("memReq after halt", memReq, 1'b0);
    end
    checkWord("number of stores", wordT'(storeIdx), wordT'(expCount));

    if (dut.busChk.errCount != 0)
      failNow("A data bus assertion failed");
    else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== dv/progInput.txt ====
// Hex words. @00 program ROM, one instruction per line
// @40 preload count then address data, @80 store count then address data in bus order
@00
1105  // addi r1, r0, 5      r1 = 0005
1213  // addi r2, r1, 3      r2 = 0008
0312  // add  r3, r1, r2     r3 = 000d
2431  // sub  r4, r3, r1     r4 = 0008
3532  // and  r5, r3, r2     r5 = 0008
4645  // nor  r6, r4, r5     r6 = fff7
9601  // sw   r6, 1(r0)
9312  // sw   r3, 2(r1)      address 0007
8704  // lw   r7, 4(r0)      r7 = 1234
1876  // addi r8, r7, 6      load-use, r8 = 123a
981f  // sw   r8, -1(r1)     address 0004
891e  // lw   r9, -2(r1)     address 0003, r9 = beef
9906  // sw   r9, 6(r0)      load-use on store data
0012  // add  r0, r1, r2     discarded
9002  // sw   r0, 2(r0)      stores zero
2a01  // sub  r10, r0, r1    r10 = fffb
9aa7  // sw   r10, 7(r10)    address wraps to 0002
f000  // hlt
9100  // sw   r1, 0(r0)      must never reach the bus
@40
0002
0004 1234
0003 beef
@80
0006
0001 fff7
0007 000d
0004 123a
0006 beef
0002 0000
0002 fffb

// ==== hdl/bypassIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface bypassIf;
  import cpuPkg::*;

  logic    dmWe;    // EX/DM result heading for a register, never a load
  regAddrT dmAddr;
  wordT    dmData;  // ALU result sitting in EX/DM
  logic    wbWe;    // DM/WB write enable
  regAddrT wbAddr;
  wordT    wbData;

  // Memory stage owns both halves
  modport source (output dmWe, dmAddr, dmData, wbWe, wbAddr, wbData);
  // Forwarding muxes in execute
  modport sink (input dmWe, dmAddr, dmData, wbWe, wbAddr, wbData);
  // Register file write port
  modport writer (input wbWe, wbAddr, wbData);

endinterface

`default_nettype wire

// ==== hdl/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu (
  input  wire logic         clk,
  input  wire logic         rst,
  output cpuPkg::wordT      pc,
  input  wire cpuPkg::wordT instr,      // Same-cycle ROM read
  output logic              memReq,
  output logic              memWe,
  output cpuPkg::wordT      memAddr,
  output cpuPkg::wordT      memWrData,
  input  wire logic         memAck,
  input  wire cpuPkg::wordT memRdData,
  output logic              hlt
);
  import cpuPkg::*;

  wordT    ifInstr;
  logic    ifValid;
  logic    hold;      // From memStage, freezes everything
  logic    stall;     // Load-use
  logic    haltSeen;
  regAddrT rdAddrA;
  regAddrT rdAddrB;
  wordT    rdDataA;
  wordT    rdDataB;
  idExT    idEx;
  exDmT    exDm;

  bypassIf byp ();  // EX/DM and DM/WB results

  fetchUnit uFetch (
    .clk, .rst, .hold, .stall, .haltSeen, .instr,
    .pc, .ifInstr, .ifValid
  );

  decodeStage uDecode (
    .clk, .rst, .hold, .ifInstr, .ifValid,
    .rdAddrA, .rdAddrB, .rdDataA, .rdDataB,
    .stall, .haltSeen, .idEx
  );

  regFile uRegs (
    .clk, .rst, .rdAddrA, .rdAddrB, .rdDataA, .rdDataB,
    .wb(byp.writer)
  );

  executeStage uExec (
    .clk, .rst, .hold, .idEx, .fwd(byp.sink), .exDm
  );

  memStage uMem (
    .clk, .rst, .exDm,
    .memReq, .memWe, .memAddr, .memWrData, .memAck, .memRdData,
    .hold, .hlt, .fwd(byp.source)
  );

endmodule

`default_nettype wire

// ==== hdl/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

  //////////////////////////////////////////////////
  // Widths and basic types
  //////////////////////////////////////////////////
  localparam int dataW    = 16;  // Word width
  localparam int regAddrW = 4;   // Register index width
  localparam int numRegs  = 16;

  typedef logic [dataW-1:0]    wordT;
  typedef logic [regAddrW-1:0] regAddrT;

  // Top nibble of the instruction
  // Codes not listed run as no-ops
  typedef enum logic [3:0] {
    opAdd  = 4'h0,
    opAddi = 4'h1,
    opSub  = 4'h2,
    opAnd  = 4'h3,
    opNor  = 4'h4,
    opLw   = 4'h8,
    opSw   = 4'h9,
    opHlt  = 4'hf
  } opcodeE;

  // Data bus master, four-phase handshake
  typedef enum logic [1:0] {
    msIdle,
    msRequest,  // memReq high, waiting for ack
    msRelease,  // memReq low, waiting for ack to drop
    msDone
  } memStateE;

  //////////////////////////////////////////////////
  // Pipeline registers
  //////////////////////////////////////////////////
  typedef struct packed {
    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    logic    halt;
    opcodeE  opcode;
    wordT    opA;        // Port A read
    wordT    opB;        // Port B read
    wordT    storeData;  // sw source register value
    wordT    imm;        // Sign-extended imm4
    logic    useImm;
    regAddrT srcA;       // Zero when not a real source
    regAddrT srcB;
    regAddrT dst;
  } idExT;

  typedef struct packed {
    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    logic    halt;
    wordT    aluRes;     // Result or memory address
    wordT    storeData;
    regAddrT dst;
  } exDmT;

endpackage

`default_nettype wire

// ==== hdl/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
  input  wire logic           clk,
  input  wire logic           rst,
  input  wire logic           hold,
  input  wire cpuPkg::wordT   ifInstr,
  input  wire logic           ifValid,
  output cpuPkg::regAddrT     rdAddrA,
  output cpuPkg::regAddrT     rdAddrB,
  input  wire cpuPkg::wordT   rdDataA,
  input  wire cpuPkg::wordT   rdDataB,
  output logic                stall,
  output logic                haltSeen,
  output cpuPkg::idExT        idEx
);
  import cpuPkg::*;

  opcodeE  opcode;
  regAddrT rd;
  regAddrT rs;
  regAddrT rt;
  logic    isRegOp;  // add, sub, and, nor
  logic    isAddi;
  logic    isLoad;
  logic    isStore;
  logic    isHalt;
  logic    usesA;
  logic    usesB;
  logic    live;     // Real instruction moving on this cycle
  idExT    idNext;

  assign opcode = opcodeE'(ifInstr[15:12]);
  assign rd     = ifInstr[11:8];
  assign rs     = ifInstr[7:4];
  assign rt     = ifInstr[3:0];

  // Opcode decode
  always_comb begin
    isRegOp = 1'b0;
    isAddi  = 1'b0;
    isLoad  = 1'b0;
    isStore = 1'b0;
    isHalt  = 1'b0;
    case (opcode)
      opAdd, opSub, opAnd, opNor: isRegOp = 1'b1;
      opAddi:  isAddi  = 1'b1;
      opLw:    isLoad  = 1'b1;
      opSw:    isStore = 1'b1;
      opHlt:   isHalt  = 1'b1;
      default: ;  // No-op
    endcase
  end

  assign usesA   = isRegOp | isAddi | isLoad | isStore;
  assign usesB   = isRegOp | isStore;
  assign rdAddrA = rs;
  assign rdAddrB = isStore ? rd : rt;  // sw data register lives in 11:8

  assign haltSeen = ifValid && isHalt;

  //////////////////////////////////////////////////
  // Load-use hazard
  //////////////////////////////////////////////////
  // Loaded value not ready until DM/WB, so hold IF/ID one cycle
  assign stall = ifValid && idEx.memRead && (idEx.dst != '0) &&
                 ((usesA && idEx.dst == rs) || (usesB && idEx.dst == rdAddrB));

  assign live = ifValid && !stall;

  always_comb begin
    idNext.regWrite  = live && (isRegOp || isAddi || isLoad);
    idNext.memRead   = live && isLoad;
    idNext.memWrite  = live && isStore;
    idNext.halt      = live && isHalt;
    idNext.opcode    = opcode;
    idNext.opA       = rdDataA;
    idNext.opB       = rdDataB;
    idNext.storeData = isStore ? rdDataB : '0;
    idNext.imm       = {{(dataW-4){ifInstr[3]}}, ifInstr[3:0]};  // imm4 sign extend
    idNext.useImm    = isAddi | isLoad | isStore;
    idNext.srcA      = usesA ? rs : '0;       // Index 0 never forwards
    idNext.srcB      = usesB ? rdAddrB : '0;
    idNext.dst       = rd;
  end

  //////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst)
      idEx <= '0;
    else if (!hold)
      idEx <= idNext;  // Flags already zero for a bubble
  end

endmodule

`default_nettype wire

// ==== hdl/executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStage (
  input  wire logic         clk,
  input  wire logic         rst,
  input  wire logic         hold,
  input  wire cpuPkg::idExT idEx,
  bypassIf.sink             fwd,
  output cpuPkg::exDmT      exDm
);
  import cpuPkg::*;

  wordT aluA;
  wordT regB;    // Forwarded port B value
  wordT aluB;
  wordT stData;  // Forwarded store data
  wordT aluOut;
  exDmT exNext;

  // Newest producer wins, EX/DM ahead of DM/WB
  function automatic wordT bypass(regAddrT src, wordT regVal);
    wordT val;
    val = regVal;
    if (src != '0) begin
      if (fwd.dmWe && fwd.dmAddr == src)
        val = fwd.dmData;
      else if (fwd.wbWe && fwd.wbAddr == src)
        val = fwd.wbData;
    end
    return val;
  endfunction

  always_comb begin
    aluA   = bypass(idEx.srcA, idEx.opA);
    regB   = bypass(idEx.srcB, idEx.opB);
    stData = bypass(idEx.srcB, idEx.storeData);
    aluB   = idEx.useImm ? idEx.imm : regB;
    case (idEx.opcode)
      opSub:   aluOut = aluA - aluB;
      opAnd:   aluOut = aluA & aluB;
      opNor:   aluOut = ~(aluA | aluB);
      default: aluOut = aluA + aluB;  // add, addi, lw/sw address
    endcase
  end

  always_comb begin
    exNext.regWrite  = idEx.regWrite;
    exNext.memRead   = idEx.memRead;
    exNext.memWrite  = idEx.memWrite;
    exNext.halt      = idEx.halt;
    exNext.aluRes    = aluOut;
    exNext.storeData = stData;
    exNext.dst       = idEx.dst;
  end

  // EX/DM register
  always_ff @(posedge clk) begin
    if (rst)
      exDm <= '0;
    else if (!hold)
      exDm <= exNext;
  end

endmodule

`default_nettype wire

// ==== hdl/fetchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchUnit (
  input  wire logic         clk,
  input  wire logic         rst,
  input  wire logic         hold,      // Bus access pending downstream
  input  wire logic         stall,     // Load-use bubble from decode
  input  wire logic         haltSeen,  // hlt sitting in IF/ID
  input  wire cpuPkg::wordT instr,
  output cpuPkg::wordT      pc,
  output cpuPkg::wordT      ifInstr,
  output logic              ifValid
);

  logic halted;   // Sticky once hlt was decoded
  logic freeze;   // Halt freeze, this cycle or earlier
  logic advance;
  logic loadIfId;

  assign freeze   = haltSeen | halted;
  assign loadIfId = !hold && !stall;     // Otherwise IF/ID keeps its entry
  assign advance  = loadIfId && !freeze;

  // PC and control bits of IF/ID
  always_ff @(posedge clk) begin
    if (rst) begin
      pc      <= '0;
      ifValid <= 1'b0;
      halted  <= 1'b0;
    end else begin
      if (haltSeen)
        halted <= 1'b1;     // Cleared only by reset
      if (advance)
        pc <= pc + 1'b1;    // Word addressed
      if (loadIfId)
        ifValid <= !freeze; // Bubbles behind the halt
    end
  end

  // Instruction payload
  always_ff @(posedge clk) begin
    if (loadIfId)
      ifInstr <= instr;
  end

endmodule

`default_nettype wire

// ==== hdl/memStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memStage (
  input  wire logic         clk,
  input  wire logic         rst,
  input  wire cpuPkg::exDmT exDm,
  output logic              memReq,
  output logic              memWe,
  output cpuPkg::wordT      memAddr,
  output cpuPkg::wordT      memWrData,
  input  wire logic         memAck,
  input  wire cpuPkg::wordT memRdData,
  output logic              hold,
  output logic              hlt,
  bypassIf.source           fwd
);
  import cpuPkg::*;

  memStateE state;
  memStateE stateNext;
  wordT     loadData;  // Captured while memAck high
  logic     access;

  assign access = exDm.memRead | exDm.memWrite;
  assign hold   = access && (state != msDone);  // Whole pipe waits on the bus

  //////////////////////////////////////////////////
  // Bus master
  //////////////////////////////////////////////////
  always_comb begin
    stateNext = state;
    case (state)
      msIdle:    if (access)  stateNext = msRequest;
      msRequest: if (memAck)  stateNext = msRelease;
      msRelease: if (!memAck) stateNext = msDone;  // Ack low ends the access
      default:   stateNext = msIdle;               // Done lasts one cycle
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst)
      state <= msIdle;
    else
      state <= stateNext;
  end

  always_ff @(posedge clk) begin
    if (state == msRequest && memAck)
      loadData <= memRdData;
  end

  // EX/DM frozen under hold, so address and data stay stable
  assign memReq    = (state == msRequest);
  assign memWe     = memReq && exDm.memWrite;
  assign memAddr   = exDm.aluRes;
  assign memWrData = exDm.storeData;

  // EX/DM half of the bypass, loads excluded
  assign fwd.dmWe   = exDm.regWrite && !exDm.memRead;
  assign fwd.dmAddr = exDm.dst;
  assign fwd.dmData = exDm.aluRes;

  //////////////////////////////////////////////////
  // DM/WB register and halt flag
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      fwd.wbWe <= 1'b0;
      hlt      <= 1'b0;
    end else if (!hold) begin
      fwd.wbWe <= exDm.regWrite;
      if (exDm.halt)
        hlt <= 1'b1;  // Sticky until reset
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      fwd.wbAddr <= exDm.dst;
      fwd.wbData <= exDm.memRead ? loadData : exDm.aluRes;  // Load data or ALU
    end
  end

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire cpuPkg::regAddrT rdAddrA,
  input  wire cpuPkg::regAddrT rdAddrB,
  output cpuPkg::wordT         rdDataA,
  output cpuPkg::wordT         rdDataB,
  bypassIf.writer              wb
);
  import cpuPkg::*;

  wordT regs [numRegs];

  // R0 reads zero, a same-cycle write passes straight through
  function automatic wordT readPort(regAddrT addr);
    if (addr == '0)
      return '0;
    if (wb.wbWe && wb.wbAddr == addr)
      return wb.wbData;
    return regs[addr];
  endfunction

  always_comb begin
    rdDataA = readPort(rdAddrA);
    rdDataB = readPort(rdAddrB);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < numRegs; i++)
        regs[i] <= '0;
    end else if (wb.wbWe && wb.wbAddr != '0) begin  // R0 writes dropped
      regs[wb.wbAddr] <= wb.wbData;
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/cpuPkg.sv
hdl/bypassIf.sv
hdl/fetchUnit.sv
hdl/decodeStage.sv
hdl/regFile.sv
hdl/executeStage.sv
hdl/memStage.sv
hdl/cpu.sv
dv/cpuBus_chk.sv
dv/cpuTb.sv
